// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := frontend_tb
FLIST     := project.f
SRCS      := $(filter-out +%,$(shell cat $(FLIST)))
BUILD     := obj_dir
BIN       := $(BUILD)/V$(TOP)
LOG       := sim.log

.PHONY: all run check clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@grep -qx 'test passed' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }
	@echo "simulation log checked"

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hw/cpu_frontend_top.sv ====
`timescale 1ns/100ps

module cpu_frontend_top #(
  parameter logic [15:0] CS_RESET = 16'h0100,
  parameter logic [15:0] DS_RESET = 16'h0200,
  parameter logic [15:0] ES_RESET = 16'h0300,
  parameter logic [15:0] SS_RESET = 16'h0400
) (
  input  logic                         clk25,
  input  logic                         rst,
  input  logic [7:0]                   din,
  output logic [x86_pkg::ADDR_W-1:0]   address,
  output logic                         insn_valid,
  output logic [15:0]                  insn_ip,
  output logic [x86_pkg::OPCODE_W-1:0] insn_opcode,
  output logic [15:0]                  insn_seg,
  output logic                         insn_seg_override,
  output logic                         insn_osize,
  output logic                         insn_asize,
  output x86_pkg::rep_e                insn_rep,
  output logic                         insn_has_modrm,
  output logic [1:0]                   insn_mod,
  output logic [2:0]                   insn_reg,
  output logic [2:0]                   insn_rm,
  output logic [15:0]                  insn_disp,
  output logic [31:0]                  insn_imm
);

  logic                 byte_take;
  logic                 insn_start;
  logic                 is_prefix;
  logic                 operands_done;
  x86_pkg::ctrl_state_e phase;
  x86_pkg::seg_sel_e    seg_sel;
  x86_pkg::imm_kind_e   imm_kind;

  decode_control u_ctrl (
    .clk25(clk25), .rst(rst), .is_prefix(is_prefix), .needs_modrm(insn_has_modrm),
    .imm_kind(imm_kind), .mod_bits(insn_mod), .rm_bits(insn_rm),
    .operands_done(operands_done), .byte_take(byte_take), .phase(phase),
    .insn_start(insn_start), .insn_valid(insn_valid)
  );

  fetch_unit #(
    .CS_RESET(CS_RESET), .DS_RESET(DS_RESET), .ES_RESET(ES_RESET), .SS_RESET(SS_RESET)
  ) u_fetch (
    .clk25(clk25), .rst(rst), .byte_take(byte_take), .insn_start(insn_start),
    .seg_sel(seg_sel), .address(address), .seg_value(insn_seg), .insn_ip(insn_ip)
  );

  // Opcode output doubles as the classifier input
  prefix_decoder u_prefix (
    .clk25(clk25), .rst(rst), .din(din), .phase(phase), .insn_start(insn_start),
    .is_prefix(is_prefix), .opcode(insn_opcode), .seg_sel(seg_sel),
    .seg_override(insn_seg_override), .osize(insn_osize), .asize(insn_asize),
    .rep(insn_rep)
  );

  opcode_classifier u_class (
    .opcode(insn_opcode), .needs_modrm(insn_has_modrm), .imm_kind(imm_kind)
  );

  operand_collector u_oper (
    .clk25(clk25), .rst(rst), .din(din), .phase(phase), .insn_start(insn_start),
    .imm_kind(imm_kind), .osize(insn_osize), .mod_bits(insn_mod), .reg_bits(insn_reg),
    .rm_bits(insn_rm), .disp(insn_disp), .imm(insn_imm), .operands_done(operands_done)
  );

endmodule

// ==== hw/decode_control.sv ====
`timescale 1ns/100ps

module decode_control (
  input  logic                 clk25,
  input  logic                 rst,
  input  logic                 is_prefix,
  input  logic                 needs_modrm,
  input  x86_pkg::imm_kind_e   imm_kind,
  input  logic [1:0]           mod_bits,
  input  logic [2:0]           rm_bits,
  input  logic                 operands_done,
  output logic                 byte_take,
  output x86_pkg::ctrl_state_e phase,
  output logic                 insn_start,
  output logic                 insn_valid
);

  x86_pkg::ctrl_state_e state;
  x86_pkg::ctrl_state_e state_nx;
  logic                 has_disp;
  logic                 has_imm;

  // Displacement follows for mod 01, mod 10 and the direct address form
  assign has_disp = (mod_bits == 2'b01) || (mod_bits == 2'b10) ||
                    (mod_bits == 2'b00 && rm_bits == 3'b110);
  assign has_imm  = (imm_kind != x86_pkg::IMM_NONE);

  always_comb begin
    state_nx = state;
    case (state)
      x86_pkg::ST_INIT: state_nx = x86_pkg::ST_FETCH;
      x86_pkg::ST_FETCH: begin
        if (is_prefix)
          state_nx = x86_pkg::ST_FETCH;      // Keep eating prefixes
        else if (needs_modrm)
          state_nx = x86_pkg::ST_MODRM;
        else if (has_imm)
          state_nx = x86_pkg::ST_IMM;
        else
          state_nx = x86_pkg::ST_INIT;       // Single byte opcode
      end
      x86_pkg::ST_MODRM: begin
        if (has_disp)
          state_nx = x86_pkg::ST_DISP;
        else if (has_imm)
          state_nx = x86_pkg::ST_IMM;
        else
          state_nx = x86_pkg::ST_INIT;
      end
      x86_pkg::ST_DISP: begin
        if (operands_done)
          state_nx = has_imm ? x86_pkg::ST_IMM : x86_pkg::ST_INIT;
      end
      x86_pkg::ST_IMM: begin
        if (operands_done)
          state_nx = x86_pkg::ST_INIT;
      end
      default: state_nx = x86_pkg::ST_INIT;
    endcase
  end

  always_ff @(posedge clk25) begin
    if (rst) begin
      state      <= x86_pkg::ST_INIT;
      insn_valid <= 1'b0;
    end else begin
      state      <= state_nx;
      // Pulse lands on the boundary cycle after the last byte
      insn_valid <= (state != x86_pkg::ST_INIT) && (state_nx == x86_pkg::ST_INIT);
    end
  end

  assign phase      = state;
  assign byte_take  = (state != x86_pkg::ST_INIT);  // Memory never stalls
  assign insn_start = (state == x86_pkg::ST_INIT);

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit #(
  parameter logic [15:0] CS_RESET = 16'h0000,
  parameter logic [15:0] DS_RESET = 16'h0000,
  parameter logic [15:0] ES_RESET = 16'h0000,
  parameter logic [15:0] SS_RESET = 16'h0000
) (
  input  logic                         clk25,
  input  logic                         rst,
  input  logic                         byte_take,   // Byte on din consumed
  input  logic                         insn_start,  // Boundary cycle
  input  x86_pkg::seg_sel_e            seg_sel,
  output logic [x86_pkg::ADDR_W-1:0]   address,
  output logic [15:0]                  seg_value,
  output logic [15:0]                  insn_ip
);

  logic [15:0] es;
  logic [15:0] cs;
  logic [15:0] ss;
  logic [15:0] ds;
  logic [15:0] ip;

  always_ff @(posedge clk25) begin
    if (rst) begin
      es      <= ES_RESET;  // Segments only come from reset
      cs      <= CS_RESET;
      ss      <= SS_RESET;
      ds      <= DS_RESET;
      ip      <= 16'h0000;
      insn_ip <= 16'h0000;
    end else begin
      if (byte_take)
        ip <= ip + 16'd1;
      if (insn_start)
        insn_ip <= ip;      // Start of the instruction about to decode
    end
  end

  // 16 * cs + ip, wraps at 1 MB
  assign address = {cs, 4'h0} + {4'h0, ip};

  always_comb begin
    case (seg_sel)
      x86_pkg::SEG_ES: seg_value = es;
      x86_pkg::SEG_CS: seg_value = cs;
      x86_pkg::SEG_SS: seg_value = ss;
      default:         seg_value = ds;
    endcase
  end

endmodule

// ==== hw/opcode_classifier.sv ====
`timescale 1ns/100ps

module opcode_classifier (
  input  logic [x86_pkg::OPCODE_W-1:0] opcode,
  output logic                         needs_modrm,
  output x86_pkg::imm_kind_e           imm_kind
);

  logic [7:0] op;
  assign op = opcode[7:0];

  // ModRM table
  always_comb begin
    if (opcode[8]) begin
      needs_modrm = (op[7:4] != 4'h8);  // 0F 8x near Jcc only
    end else begin
      casez (op)
        8'b00???0??,                    // ALU r/m forms
        8'b1000????,                    // Group 1, MOV, TEST, XCHG, LEA, POP
        8'b0110001?,                    // BOUND, ARPL
        8'h69, 8'h6B,                   // IMUL
        8'b1100000?,                    // Shift group imm
        8'b110001??,                    // LES, LDS, MOV imm
        8'b110100??,                    // Shift group 1, CL
        8'b11011???,                    // FPU escape
        8'b1111011?,                    // Group 3
        8'b1111111?: needs_modrm = 1'b1;  // Group 4, 5
        default:     needs_modrm = 1'b0;
      endcase
    end
  end

  // Immediate table
  always_comb begin
    if (opcode[8]) begin
      imm_kind = (op[7:4] == 4'h8) ? x86_pkg::IMM_WORD : x86_pkg::IMM_NONE;
    end else begin
      casez (op)
        8'b00???100,                    // ALU AL, imm8
        8'h6A, 8'h6B,
        8'b0111????,                    // Short Jcc
        8'h80, 8'h82, 8'h83,
        8'hA8,
        8'b10110???,                    // MOV r8, imm8
        8'hC0, 8'hC1, 8'hC6,
        8'hCD,                          // INT n
        8'hE4, 8'hE6,                   // IN, OUT imm port
        8'hEB:       imm_kind = x86_pkg::IMM_BYTE;
        8'b00???101,                    // ALU AX, imm16
        8'h68, 8'h69, 8'h81,
        8'hA9,
        8'b10111???,                    // MOV r16, imm16
        8'hC7,
        8'hE8, 8'hE9: imm_kind = x86_pkg::IMM_WORD;  // Near CALL, JMP
        default:      imm_kind = x86_pkg::IMM_NONE;
      endcase
    end
  end

endmodule

// ==== hw/operand_collector.sv ====
`timescale 1ns/100ps

module operand_collector (
  input  logic                 clk25,
  input  logic                 rst,
  input  logic [7:0]           din,
  input  x86_pkg::ctrl_state_e phase,
  input  logic                 insn_start,
  input  x86_pkg::imm_kind_e   imm_kind,
  input  logic                 osize,
  output logic [1:0]           mod_bits,
  output logic [2:0]           reg_bits,
  output logic [2:0]           rm_bits,
  output logic [15:0]          disp,
  output logic [31:0]          imm,
  output logic                 operands_done
);

  logic [7:0] modrm_q;
  logic [1:0] cnt;        // Byte index within DISP or IMM
  logic       disp_last;  // Index of last displacement byte
  logic [1:0] imm_last;
  logic       is_modrm;

  assign is_modrm = (phase == x86_pkg::ST_MODRM);

  // Fields pass straight from din during the ModRM cycle
  assign mod_bits = is_modrm ? din[7:6] : modrm_q[7:6];
  assign reg_bits = is_modrm ? din[5:3] : modrm_q[5:3];
  assign rm_bits  = is_modrm ? din[2:0] : modrm_q[2:0];

  assign disp_last = (modrm_q[7:6] != 2'b01);  // mod 01 has a single byte

  always_comb begin
    case (imm_kind)
      x86_pkg::IMM_WORD: imm_last = osize ? 2'd3 : 2'd1;
      default:           imm_last = 2'd0;
    endcase
  end

  assign operands_done = (phase == x86_pkg::ST_DISP && cnt == {1'b0, disp_last}) ||
                         (phase == x86_pkg::ST_IMM && cnt == imm_last);

  always_ff @(posedge clk25) begin
    if (rst || insn_start) begin
      modrm_q <= 8'h00;
      disp    <= 16'h0000;
      imm     <= 32'h0000_0000;
      cnt     <= 2'd0;
    end else begin
      case (phase)
        x86_pkg::ST_MODRM: modrm_q <= din;
        x86_pkg::ST_DISP: begin
          if (cnt == 2'd0)
            disp <= (modrm_q[7:6] == 2'b01) ? {{8{din[7]}}, din} : {8'h00, din};
          else
            disp[15:8] <= din;   // Little endian high byte
          cnt <= operands_done ? 2'd0 : cnt + 2'd1;
        end
        x86_pkg::ST_IMM: begin
          imm[{cnt, 3'b000} +: 8] <= din;
          cnt <= operands_done ? 2'd0 : cnt + 2'd1;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== hw/prefix_decoder.sv ====
`timescale 1ns/100ps

module prefix_decoder (
  input  logic                          clk25,
  input  logic                          rst,
  input  logic [7:0]                    din,
  input  x86_pkg::ctrl_state_e          phase,
  input  logic                          insn_start,
  output logic                          is_prefix,
  output logic [x86_pkg::OPCODE_W-1:0]  opcode,
  output x86_pkg::seg_sel_e             seg_sel,
  output logic                          seg_override,
  output logic                          osize,        // 0 is 16 bit, 1 is 32 bit
  output logic                          asize,
  output x86_pkg::rep_e                 rep
);

  logic       esc;    // 0F seen
  logic [7:0] op_lo;  // Latched opcode byte

  // Byte after 0F is always the opcode
  always_comb begin
    is_prefix = 1'b0;
    if (phase == x86_pkg::ST_FETCH && !esc) begin
      case (din)
        8'h0F, 8'h26, 8'h2E, 8'h36, 8'h3E,
        8'h64, 8'h65, 8'h66, 8'h67,
        8'hF0, 8'hF2, 8'hF3: is_prefix = 1'b1;
        default:             is_prefix = 1'b0;
      endcase
    end
  end

  // Live byte while fetching so the classifier sees it the same cycle
  assign opcode = (phase == x86_pkg::ST_FETCH) ? {esc, din} : {esc, op_lo};

  always_ff @(posedge clk25) begin
    if (rst || insn_start) begin
      esc          <= 1'b0;
      seg_sel      <= x86_pkg::SEG_DS;
      seg_override <= 1'b0;
      osize        <= 1'b0;
      asize        <= 1'b0;
      rep          <= x86_pkg::REP_NONE;
    end else if (phase == x86_pkg::ST_FETCH) begin
      if (is_prefix) begin
        case (din)
          8'h0F: esc <= 1'b1;            // Two-byte opcode map
          8'h26: begin
            seg_sel      <= x86_pkg::SEG_ES;
            seg_override <= 1'b1;
          end
          8'h2E: begin
            seg_sel      <= x86_pkg::SEG_CS;
            seg_override <= 1'b1;
          end
          8'h36: begin
            seg_sel      <= x86_pkg::SEG_SS;
            seg_override <= 1'b1;
          end
          8'h3E: begin
            seg_sel      <= x86_pkg::SEG_DS;  // Explicit DS still counts
            seg_override <= 1'b1;
          end
          8'h66: osize <= ~osize;        // Repeats toggle back
          8'h67: asize <= ~asize;
          8'hF2: rep <= x86_pkg::REP_NZ;
          8'hF3: rep <= x86_pkg::REP_Z;
          default: ;                     // LOCK, FS, GS dropped
        endcase
      end else begin
        op_lo <= din;
      end
    end
  end

endmodule

// ==== hw/x86_pkg.sv ====
package x86_pkg;

  // Opcode word, escape bit on top of the opcode byte
  localparam int OPCODE_W = 9;

  // Real-mode linear address width
  localparam int ADDR_W = 20;

  // Decode sequencer states
  typedef enum logic [2:0] {
    ST_INIT  = 3'd0,   // Instruction boundary, no byte taken
    ST_FETCH = 3'd1,   // Prefixes and opcode
    ST_MODRM = 3'd2,   // ModRM byte
    ST_DISP  = 3'd3,   // Displacement bytes
    ST_IMM   = 3'd4    // Immediate bytes
  } ctrl_state_e;

  // Segment register choice
  typedef enum logic [1:0] {
    SEG_ES = 2'd0,
    SEG_CS = 2'd1,
    SEG_SS = 2'd2,
    SEG_DS = 2'd3     // Default data segment
  } seg_sel_e;

  // Repeat prefix
  typedef enum logic [1:0] {
    REP_NONE = 2'd0,
    REP_Z    = 2'd1,  // F3
    REP_NZ   = 2'd2   // F2
  } rep_e;

  // Immediate class of an opcode
  // Word means 2 bytes, 4 with the operand size prefix
  typedef enum logic [1:0] {
    IMM_NONE = 2'd0,
    IMM_BYTE = 2'd1,
    IMM_WORD = 2'd2
  } imm_kind_e;

endpackage

// ==== project.f ====
hw/x86_pkg.sv
hw/fetch_unit.sv
hw/prefix_decoder.sv
hw/opcode_classifier.sv
hw/operand_collector.sv
hw/decode_control.sv
hw/cpu_frontend_top.sv
testbench/frontend_tb.sv

// ==== testbench/frontend_tb.sv ====
`timescale 1ns/100ps

module frontend_tb;

  // Distinct segment bases so a wrong pick shows
  localparam logic [15:0] CS_P = 16'h0800;
  localparam logic [15:0] DS_P = 16'h1a2b;
  localparam logic [15:0] ES_P = 16'h3c4d;
  localparam logic [15:0] SS_P = 16'h5e6f;

  // Expected record of one instruction
  typedef struct packed {
    logic [63:0]   bytes;      // Reading order with the last byte in bits 7:0
    logic [3:0]    len;
    logic [8:0]    opcode;     // Escape bit on top
    logic [15:0]   seg;
    logic          ovr;
    logic          osize;
    logic          asize;
    x86_pkg::rep_e rep;
    logic          has_modrm;
    logic [7:0]    modrm;
    logic [15:0]   disp;
    logic [31:0]   imm;
  } insn_rec_t;

  logic          clk25;
  logic          rst;
  logic [7:0]    din;
  logic [19:0]   address;
  logic          insn_valid;
  logic [15:0]   insn_ip;
  logic [8:0]    insn_opcode;
  logic [15:0]   insn_seg;
  logic          insn_seg_override;
  logic          insn_osize;
  logic          insn_asize;
  x86_pkg::rep_e insn_rep;
  logic          insn_has_modrm;
  logic [1:0]    insn_mod;
  logic [2:0]    insn_reg;
  logic [2:0]    insn_rm;
  logic [15:0]   insn_disp;
  logic [31:0]   insn_imm;

  logic [7:0]    mem [0:(1 << 20) - 1];  // Full real-mode space
  insn_rec_t     tbl [0:31];
  string         tbl_name [0:31];
  logic [15:0]   tbl_ip [0:31];          // Running byte offset
  int            n_entries;
  int            prog_len;
  int            seed;
  logic          table_ready;

  cpu_frontend_top #(
    .CS_RESET(CS_P), .DS_RESET(DS_P), .ES_RESET(ES_P), .SS_RESET(SS_P)
  ) dut (
    .clk25(clk25), .rst(rst), .din(din), .address(address), .insn_valid(insn_valid),
    .insn_ip(insn_ip), .insn_opcode(insn_opcode), .insn_seg(insn_seg),
    .insn_seg_override(insn_seg_override), .insn_osize(insn_osize),
    .insn_asize(insn_asize), .insn_rep(insn_rep), .insn_has_modrm(insn_has_modrm),
    .insn_mod(insn_mod), .insn_reg(insn_reg), .insn_rm(insn_rm),
    .insn_disp(insn_disp), .insn_imm(insn_imm)
  );

  assign din = mem[address];  // Zero wait state memory

  initial begin
    clk25 = 1'b0;
    forever #4 clk25 = ~clk25;
  end

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input string field,
                                 input string exp, input string act);
    $display("Error %s %s expected %s actual %s", name, field, exp, act);
    abort_run();
  endtask

  task automatic check_word(input string name, input string field,
                            input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp)
      report_mismatch(name, field, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_long(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (act !== exp)
      report_mismatch(name, "imm", $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_addr(input string name, input logic [19:0] exp,
                            input logic [19:0] act);
    if (act !== exp)
      report_mismatch(name, "address", $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_opcode(input string name, input logic [8:0] exp,
                              input logic [8:0] act);
    if (act !== exp)
      report_mismatch(name, "opcode", $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_rep(input string name, input x86_pkg::rep_e exp,
                           input x86_pkg::rep_e act);
    if (act !== exp)
      report_mismatch(name, "rep", exp.name(), act.name());
  endtask

  task automatic check_modrm(input string name, input logic [7:0] exp,
                             input logic [7:0] act);
    if (act !== exp)
      report_mismatch(name, "modrm", $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_bit(input string name, input string field,
                           input logic exp, input logic act);
    if (act !== exp)
      report_mismatch(name, field, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  // Appends one entry and lays its bytes into memory after the previous one
  // Flags are {override, osize, asize}
  // Top bit of modrm marks it present
  task automatic add_insn(input string name, input int len, input logic [63:0] bytes,
                          input logic [8:0] opcode, input logic [15:0] seg,
                          input logic [2:0] flags, input x86_pkg::rep_e rep,
                          input logic [8:0] modrm, input logic [15:0] disp,
                          input logic [31:0] imm);
    logic [19:0] a;
    insn_rec_t   e;
    e = {bytes, len[3:0], opcode, seg, flags, rep, modrm, disp, imm};
    tbl_name[n_entries] = name;
    tbl_ip[n_entries]   = prog_len[15:0];
    tbl[n_entries]      = e;
    for (int i = 0; i < int'(e.len); i++) begin
      a = 20'(CS_P) * 20'd16 + 20'(prog_len + i);
      mem[a] = 8'(e.bytes >> (8 * (int'(e.len) - 1 - i)));
    end
    prog_len += int'(e.len);
    n_entries++;
  endtask

  task automatic build_table();
    logic [7:0]  d8;
    logic [7:0]  i8;
    logic [15:0] d16a;
    logic [15:0] d16b;
    logic [15:0] d16c;
    logic [15:0] i16a;
    logic [15:0] i16b;
    logic [15:0] i16c;
    logic [15:0] i16d;
    logic [31:0] i32;
    d8   = 8'($random(seed)) | 8'h80;  // Negative so sign extension shows
    i8   = 8'($random(seed));
    d16a = 16'($random(seed));
    d16b = 16'($random(seed));
    d16c = 16'($random(seed));
    i16a = 16'($random(seed));
    i16b = 16'($random(seed));
    i16c = 16'($random(seed));
    i16d = 16'($random(seed));
    i32  = $random(seed);
    add_insn("nop", 1, 64'h90, 9'h090, DS_P, 3'b000,
             x86_pkg::REP_NONE, 9'h000, 16'h0000, 32'h0);
    add_insn("clc", 1, 64'hF8, 9'h0F8, DS_P, 3'b000,
             x86_pkg::REP_NONE, 9'h000, 16'h0000, 32'h0);
    add_insn("es_override", 2, 64'h2690, 9'h090, ES_P, 3'b100,
             x86_pkg::REP_NONE, 9'h000, 16'h0000, 32'h0);
    add_insn("cs_override", 2, 64'h2E90, 9'h090, CS_P, 3'b100,
             x86_pkg::REP_NONE, 9'h000, 16'h0000, 32'h0);
    add_insn("ss_override", 2, 64'h3690, 9'h090, SS_P, 3'b100,
             x86_pkg::REP_NONE, 9'h000, 16'h0000, 32'h0);
    add_insn("ds_override", 2, 64'h3E90, 9'h090, DS_P, 3'b100,
             x86_pkg::REP_NONE, 9'h000, 16'h0000, 32'h0);
    // Word immediate grows to 4 bytes under 66
    add_insn("osize_imm32", 6,
             64'({8'h66, 8'hB8, i32[7:0], i32[15:8], i32[23:16], i32[31:24]}),
             9'h0B8, DS_P, 3'b010, x86_pkg::REP_NONE, 9'h000, 16'h0000, i32);
    add_insn("osize_twice", 5, 64'({8'h66, 8'h66, 8'hB8, i16a[7:0], i16a[15:8]}),
             9'h0B8, DS_P, 3'b000, x86_pkg::REP_NONE, 9'h000, 16'h0000, {16'h0, i16a});
    add_insn("asize", 2, 64'h6790, 9'h090, DS_P, 3'b001,
             x86_pkg::REP_NONE, 9'h000, 16'h0000, 32'h0);
    add_insn("repnz", 2, 64'hF2A6, 9'h0A6, DS_P, 3'b000,
             x86_pkg::REP_NZ, 9'h000, 16'h0000, 32'h0);
    add_insn("repz", 2, 64'hF3A4, 9'h0A4, DS_P, 3'b000,
             x86_pkg::REP_Z, 9'h000, 16'h0000, 32'h0);
    add_insn("modrm_reg", 2, 64'h89D8, 9'h089, DS_P, 3'b000,
             x86_pkg::REP_NONE, 9'h1D8, 16'h0000, 32'h0);
    // Byte is negative so the upper half fills with ones
    add_insn("modrm_disp8", 3, 64'({8'h8B, 8'h47, d8}), 9'h08B, DS_P, 3'b000,
             x86_pkg::REP_NONE, 9'h147, {8'hFF, d8}, 32'h0);
    add_insn("modrm_disp16", 4, 64'({8'h8B, 8'h97, d16a[7:0], d16a[15:8]}), 9'h08B,
             DS_P, 3'b000, x86_pkg::REP_NONE, 9'h197, d16a, 32'h0);
    add_insn("modrm_direct", 4, 64'({8'h8B, 8'h1E, d16b[7:0], d16b[15:8]}), 9'h08B,
             DS_P, 3'b000, x86_pkg::REP_NONE, 9'h11E, d16b, 32'h0);
    add_insn("imm8", 2, 64'({8'h04, i8}), 9'h004, DS_P, 3'b000,
             x86_pkg::REP_NONE, 9'h000, 16'h0000, {24'h0, i8});
    add_insn("imm16", 3, 64'({8'h05, i16b[7:0], i16b[15:8]}), 9'h005, DS_P, 3'b000,
             x86_pkg::REP_NONE, 9'h000, 16'h0000, {16'h0, i16b});
    // ModRM, then displacement, then immediate
    add_insn("modrm_disp_imm", 6,
             64'({8'h81, 8'h87, d16c[7:0], d16c[15:8], i16c[7:0], i16c[15:8]}),
             9'h081, DS_P, 3'b000, x86_pkg::REP_NONE, 9'h187, d16c, {16'h0, i16c});
    add_insn("esc_jcc", 4, 64'({8'h0F, 8'h84, i16d[7:0], i16d[15:8]}), 9'h184, DS_P,
             3'b000, x86_pkg::REP_NONE, 9'h000, 16'h0000, {16'h0, i16d});
    add_insn("esc_modrm", 3, 64'h0FB6C1, 9'h1B6, DS_P, 3'b000,
             x86_pkg::REP_NONE, 9'h1C1, 16'h0000, 32'h0);
  endtask

  task automatic check_entry(input int k);
    insn_rec_t   e;
    string       n;
    logic [19:0] exp_addr;
    e = tbl[k];
    n = tbl_name[k];
    // Fetch already points at the next instruction's first byte
    exp_addr = 20'(CS_P) * 20'd16 + 20'(tbl_ip[k]) + 20'(e.len);
    check_word(n, "ip", tbl_ip[k], insn_ip);
    check_opcode(n, e.opcode, insn_opcode);
    check_word(n, "segment", e.seg, insn_seg);
    check_bit(n, "override", e.ovr, insn_seg_override);
    check_bit(n, "osize", e.osize, insn_osize);
    check_bit(n, "asize", e.asize, insn_asize);
    check_rep(n, e.rep, insn_rep);
    check_bit(n, "has_modrm", e.has_modrm, insn_has_modrm);
    check_modrm(n, e.modrm, {insn_mod, insn_reg, insn_rm});
    check_word(n, "disp", e.disp, insn_disp);
    check_long(n, e.imm, insn_imm);
    check_addr(n, exp_addr, address);
  endtask

  initial begin
    rst         = 1'b1;
    table_ready = 1'b0;
    seed        = 32'ha4bb759d;
    n_entries   = 0;
    prog_len    = 0;
    for (int a = 0; a < (1 << 20); a++)
      mem[a[19:0]] = a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]};  // Fill mixes every address bit
    build_table();
    table_ready = 1'b1;
    repeat (5) @(posedge clk25);
    rst <= 1'b0;
    for (int k = 0; k < n_entries; k++) begin
      do
        @(negedge clk25);  // Record settled by mid-cycle
      while (!insn_valid);
      check_entry(k);
    end
    $display("test passed");
    $finish;
  end

  // Decode budget from the table size plus reset cycles
  initial begin
    wait (table_ready);
    repeat (5 + 2 * prog_len + n_entries + 20) @(posedge clk25);
    $display("Watchdog expired before every instruction was decoded");
    abort_run();
  end

endmodule
